//--- Bender.yml
package:
  name: uartAxiBridge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/uartAxiBridgePkg.sv
      - hw/frameReceiver.sv
      - hw/commandEngine.sv
      - hw/responseQueue.sv
      - hw/frameTransmitter.sv
      - hw/uartAxiBridge.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/uartAxiBridge_properties.sv
      - tests/uartAxiBridgeTb.sv

//--- hw/commandEngine.sv
// Command engine that dispatches commands, masters AXI-Lite and builds response messages
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module commandEngine
  import uartAxiBridgePkg::*;
(
  input  logic                   clk,
  input  logic                   axi_resetn,
  input  logic                   cmdValid,
  input  logic [7:0]             cmdByte,
  input  logic [7:0]             cmdSeq,
  input  logic [63:0]            cmdAddr,
  input  logic [31:0]            cmdData,
  output logic [31:0]            axi_awaddr,
  output logic                   axi_awvalid,
  input  logic                   axi_awready,
  output logic [31:0]            axi_wdata,
  output logic                   axi_wvalid,
  input  logic                   axi_wready,
  input  logic [1:0]             axi_bresp,
  input  logic                   axi_bvalid,
  output logic                   axi_bready,
  output logic [31:0]            axi_araddr,
  output logic                   axi_arvalid,
  input  logic                   axi_arready,
  input  logic [31:0]            axi_rdata,
  input  logic [1:0]             axi_rresp,
  input  logic                   axi_rvalid,
  output logic                   axi_rready,
  input  logic                   respFull,
  output logic                   respPush,
  output logic [`MSG_BYTES*8-1:0] respMsg
);

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_DONE} readStateE;
  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP, WR_DONE} writeStateE;

  readStateE  rdState;
  writeStateE wrState;
  cmdOpcodeE  opcode;

  logic awDone, wDone, awHs, wHs;
  logic immValid, immPush, startRead, startWrite;
  logic rdPushOk, wrPushOk;
  logic [`MSG_BYTES*8-1:0] immMsg;

  // Transfer context kept for the echo in the response
  logic [7:0]  rdSeq, wrSeq;
  logic [63:0] rdAddr, wrAddr;
  logic [31:0] rdData, wrData;
  logic [1:0]  rdResp, wrResp;

  assign opcode = cmdOpcodeE'(cmdByte[5:0]);

  always_comb
  begin
    case (opcode)
      OP_NOP:
      begin
        immValid = 1'b1;
        immMsg   = {2'b00, RSP_NOP, cmdSeq, `NOP_ADDR_SIG, `NOP_DATA_SIG};
      end
      OP_READ:
      begin
        immValid = (rdState != RD_IDLE);
        immMsg   = {2'b00, RSP_BUSY_READ, cmdSeq, cmdAddr, 32'h0};
      end
      OP_WRITE:
      begin
        immValid = (wrState != WR_IDLE);
        immMsg   = {2'b00, RSP_BUSY_WRITE, cmdSeq, cmdAddr, cmdData};
      end
      default:
      begin
        immValid = 1'b1;
        immMsg   = {2'b00, RSP_INVALID, cmdSeq, `BAD_ADDR_SIG, `BAD_DATA_SIG};
      end
    endcase
  end

  assign immPush    = cmdValid && immValid;
  assign startRead  = cmdValid && (opcode == OP_READ) && (rdState == RD_IDLE);
  assign startWrite = cmdValid && (opcode == OP_WRITE) && (wrState == WR_IDLE);

  // Full flag lags a push by one cycle, so results never push back to back
  assign rdPushOk = (rdState == RD_DONE) && !respFull && !respPush && !immPush;
  assign wrPushOk = (wrState == WR_DONE) && !respFull && !respPush && !immPush && !rdPushOk;

  assign axi_arvalid = (rdState == RD_ADDR);
  assign axi_rready  = (rdState != RD_DONE);
  assign axi_awvalid = (wrState == WR_REQ) && !awDone;
  assign axi_wvalid  = (wrState == WR_REQ) && !wDone;
  assign axi_bready  = (wrState != WR_DONE);
  assign awHs        = axi_awvalid && axi_awready;
  assign wHs         = axi_wvalid && axi_wready;

  assign axi_araddr = rdAddr[31:0];
  assign axi_awaddr = wrAddr[31:0];
  assign axi_wdata  = wrData;

  always_ff @(posedge clk)
  begin
    if (!axi_resetn)
    begin
      rdState  <= RD_IDLE;
      wrState  <= WR_IDLE;
      awDone   <= 1'b0;
      wDone    <= 1'b0;
      respPush <= 1'b0;
    end
    else
    begin
      // Immediate answers that meet a full queue are lost
      respPush <= (immPush && !respFull) || rdPushOk || wrPushOk;

      case (rdState)
        RD_IDLE: if (startRead) rdState <= RD_ADDR;
        RD_ADDR: if (axi_arready) rdState <= RD_DATA;
        RD_DATA: if (axi_rvalid) rdState <= RD_DONE;
        RD_DONE: if (rdPushOk) rdState <= RD_IDLE;
      endcase

      case (wrState)
        WR_IDLE:
        begin
          if (startWrite)
          begin
            wrState <= WR_REQ;
            awDone  <= 1'b0;
            wDone   <= 1'b0;
          end
        end
        WR_REQ:
        begin
          // Address and data may complete in either order
          awDone <= awDone || awHs;
          wDone  <= wDone || wHs;
          if ((awDone || awHs) && (wDone || wHs))
            wrState <= WR_RESP;
        end
        WR_RESP: if (axi_bvalid) wrState <= WR_DONE;
        WR_DONE: if (wrPushOk) wrState <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (startRead)
    begin
      rdSeq  <= cmdSeq;
      rdAddr <= cmdAddr;
    end
    if ((rdState == RD_DATA) && axi_rvalid)
    begin
      rdData <= axi_rdata;
      rdResp <= axi_rresp;
    end
    if (startWrite)
    begin
      wrSeq  <= cmdSeq;
      wrAddr <= cmdAddr;
      wrData <= cmdData;
    end
    if ((wrState == WR_RESP) && axi_bvalid)
      wrResp <= axi_bresp;

    if (immPush)
      respMsg <= immMsg;
    else if (rdPushOk)
      respMsg <= {rdResp, RSP_READ, rdSeq, rdAddr, rdData};
    else if (wrPushOk)
      respMsg <= {wrResp, RSP_WRITE, wrSeq, wrAddr, wrData};
  end

endmodule

//--- hw/frameReceiver.sv
// Frame receiver that slides a 16-byte window over the input and strobes out CRC-valid commands
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module frameReceiver
  import uartAxiBridgePkg::*;
(
  input  logic        clk,
  input  logic        axi_resetn,
  input  logic [7:0]  rxByte,
  input  logic        rxByteValid,
  output logic        cmdValid,
  output logic [7:0]  cmdByte,
  output logic [7:0]  cmdSeq,
  output logic [63:0] cmdAddr,
  output logic [31:0] cmdData
);

  logic [`FRAME_BYTES*8-1:0] rxWindow;
  logic [`FRAME_BYTES*8-1:0] nextWindow;
  logic [4:0]                byteCount;
  logic [15:0]               calcCrc;
  logic [15:0]               rxCrc;
  logic                      frameMatch;

  // Window as it looks once the incoming byte is shifted in
  assign nextWindow = {rxWindow[`FRAME_BYTES*8-9:0], rxByte};

  // CRC travels low byte first, so the high byte is the newest
  assign rxCrc = {nextWindow[7:0], nextWindow[15:8]};

  always_comb
  begin
    calcCrc = `CRC16_INIT;
    for (int i = 0; i < `MSG_BYTES; i++)
    begin
      calcCrc = crc16Update(calcCrc, nextWindow[`FRAME_BYTES*8-1-8*i -: 8]);
    end
  end

  // Only test once the window holds a full frame
  assign frameMatch = rxByteValid && (byteCount >= 5'(`FRAME_BYTES - 1)) &&
                      (calcCrc == rxCrc);

  always_ff @(posedge clk)
  begin
    if (!axi_resetn)
    begin
      byteCount <= '0;
      cmdValid  <= 1'b0;
    end
    else
    begin
      cmdValid <= frameMatch;
      if (rxByteValid)
      begin
        // Good frame restarts the window, otherwise keep sliding
        if (frameMatch)
          byteCount <= '0;
        else if (byteCount < 5'(`FRAME_BYTES))
          byteCount <= byteCount + 5'd1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rxByteValid)
      rxWindow <= nextWindow;
    if (frameMatch)
    begin
      cmdByte <= nextWindow[127:120];
      cmdSeq  <= nextWindow[119:112];
      cmdAddr <= nextWindow[111:48];
      cmdData <= nextWindow[47:16];
    end
  end

endmodule

//--- hw/frameTransmitter.sv
// Frame transmitter that sends queued responses byte by byte and appends the CRC-16
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module frameTransmitter
  import uartAxiBridgePkg::*;
(
  input  logic                    clk,
  input  logic                    axi_resetn,
  input  logic [`MSG_BYTES*8-1:0] respHead,
  input  logic                    respEmpty,
  output logic                    respPop,
  input  logic                    txReady,
  output logic [7:0]              txByte,
  output logic                    txByteStrobe
);

  typedef enum logic {TX_IDLE, TX_SEND} txStateE;

  txStateE                 txState;
  logic [`MSG_BYTES*8-1:0] txShift;
  logic [15:0]             txCrc;
  logic [3:0]              byteIdx;
  logic                    lastStrobe;

  // Take the head entry as soon as we are free
  assign respPop = (txState == TX_IDLE) && !respEmpty;

  // At most one byte per two cycles, and only while the sink is ready
  assign txByteStrobe = (txState == TX_SEND) && txReady && !lastStrobe;

  always_comb
  begin
    if (byteIdx < 4'(`MSG_BYTES))
      txByte = txShift[`MSG_BYTES*8-1 -: 8];
    else if (byteIdx == 4'(`MSG_BYTES))
      txByte = txCrc[7:0];
    else
      txByte = txCrc[15:8];
  end

  always_ff @(posedge clk)
  begin
    if (!axi_resetn)
    begin
      txState    <= TX_IDLE;
      byteIdx    <= '0;
      lastStrobe <= 1'b0;
    end
    else
    begin
      lastStrobe <= txByteStrobe;
      if (respPop)
      begin
        txState <= TX_SEND;
        byteIdx <= '0;
      end
      else if (txByteStrobe)
      begin
        byteIdx <= byteIdx + 4'd1;
        if (byteIdx == 4'(`FRAME_BYTES - 1))
          txState <= TX_IDLE;
      end
    end
  end

  // Running CRC over message bytes as they leave
  always_ff @(posedge clk)
  begin
    if (respPop)
    begin
      txShift <= respHead;
      txCrc   <= `CRC16_INIT;
    end
    else if (txByteStrobe && (byteIdx < 4'(`MSG_BYTES)))
    begin
      txShift <= {txShift[`MSG_BYTES*8-9:0], 8'h00};
      txCrc   <= crc16Update(txCrc, txShift[`MSG_BYTES*8-1 -: 8]);
    end
  end

endmodule

//--- hw/responseQueue.sv
// Response queue holding 14-byte response messages in a circular FIFO
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module responseQueue #(
  parameter int DEPTH = `RESP_DEPTH
) (
  input  logic                    clk,
  input  logic                    axi_resetn,
  input  logic                    respPush,
  input  logic [`MSG_BYTES*8-1:0] respMsg,
  input  logic                    respPop,
  output logic [`MSG_BYTES*8-1:0] respHead,
  output logic                    respFull,
  output logic                    respEmpty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [`MSG_BYTES*8-1:0] queueMem [DEPTH];
  logic [PTR_W-1:0]        wrPtr;
  logic [PTR_W-1:0]        rdPtr;
  logic [PTR_W:0]          count;
  logic                    doPush;
  logic                    doPop;

  // Overflow and underflow requests are ignored
  assign doPush = respPush && !respFull;
  assign doPop  = respPop && !respEmpty;

  assign respHead  = queueMem[rdPtr];
  assign respFull  = (count == (PTR_W+1)'(DEPTH));
  assign respEmpty = (count == '0);

  always_ff @(posedge clk)
  begin
    if (!axi_resetn)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (doPush)
      queueMem[wrPtr] <= respMsg;
  end

endmodule

//--- hw/uartAxiBridge.sv
// Bridge top level with byte streams in and out and an AXI4-Lite master toward the system
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module uartAxiBridge (
  input  logic        clk,
  input  logic        axi_resetn,
  input  logic [7:0]  rxByte,
  input  logic        rxByteValid,
  input  logic        txReady,
  output logic [7:0]  txByte,
  output logic        txByteStrobe,
  output logic [31:0] axi_awaddr,
  output logic [2:0]  axi_awprot,
  output logic        axi_awvalid,
  input  logic        axi_awready,
  output logic [31:0] axi_wdata,
  output logic [3:0]  axi_wstrb,
  output logic        axi_wvalid,
  input  logic        axi_wready,
  input  logic [1:0]  axi_bresp,
  input  logic        axi_bvalid,
  output logic        axi_bready,
  output logic [31:0] axi_araddr,
  output logic [2:0]  axi_arprot,
  output logic        axi_arvalid,
  input  logic        axi_arready,
  input  logic [31:0] axi_rdata,
  input  logic [1:0]  axi_rresp,
  input  logic        axi_rvalid,
  output logic        axi_rready
);

  logic                    cmdValid;
  logic [7:0]              cmdByte;
  logic [7:0]              cmdSeq;
  logic [63:0]             cmdAddr;
  logic [31:0]             cmdData;
  logic                    respPush;
  logic [`MSG_BYTES*8-1:0] respMsg;
  logic                    respPop;
  logic [`MSG_BYTES*8-1:0] respHead;
  logic                    respFull;
  logic                    respEmpty;

  // Full-word writes only with fixed protection
  assign axi_awprot = `AXI_PROT_VALUE;
  assign axi_arprot = `AXI_PROT_VALUE;
  assign axi_wstrb  = 4'hF;

  frameReceiver i_frameReceiver (
    .clk(clk), .axi_resetn(axi_resetn),
    .rxByte(rxByte), .rxByteValid(rxByteValid),
    .cmdValid(cmdValid), .cmdByte(cmdByte), .cmdSeq(cmdSeq),
    .cmdAddr(cmdAddr), .cmdData(cmdData)
  );

  commandEngine i_commandEngine (
    .clk(clk), .axi_resetn(axi_resetn),
    .cmdValid(cmdValid), .cmdByte(cmdByte), .cmdSeq(cmdSeq),
    .cmdAddr(cmdAddr), .cmdData(cmdData),
    .axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
    .axi_wdata(axi_wdata), .axi_wvalid(axi_wvalid), .axi_wready(axi_wready),
    .axi_bresp(axi_bresp), .axi_bvalid(axi_bvalid), .axi_bready(axi_bready),
    .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
    .axi_rdata(axi_rdata), .axi_rresp(axi_rresp), .axi_rvalid(axi_rvalid),
    .axi_rready(axi_rready),
    .respFull(respFull), .respPush(respPush), .respMsg(respMsg)
  );

  responseQueue #(.DEPTH(`RESP_DEPTH)) i_responseQueue (
    .clk(clk), .axi_resetn(axi_resetn),
    .respPush(respPush), .respMsg(respMsg), .respPop(respPop),
    .respHead(respHead), .respFull(respFull), .respEmpty(respEmpty)
  );

  frameTransmitter i_frameTransmitter (
    .clk(clk), .axi_resetn(axi_resetn),
    .respHead(respHead), .respEmpty(respEmpty), .respPop(respPop),
    .txReady(txReady), .txByte(txByte), .txByteStrobe(txByteStrobe)
  );

endmodule

//--- hw/uartAxiBridgePkg.sv
// Bridge package with command and response codes plus the CRC-16 byte update
`include "uartAxiBridge_macros.svh"

package uartAxiBridgePkg;

  // Low six bits of a command byte
  typedef enum logic [5:0]
  {
    OP_NOP   = 6'd0,
    OP_READ  = 6'd1,
    OP_WRITE = 6'd2
  } cmdOpcodeE;

  // Low six bits of a response byte with the AXI resp code above them
  typedef enum logic [5:0]
  {
    RSP_NOP        = 6'd0,
    RSP_READ       = 6'd1,
    RSP_WRITE      = 6'd2,
    RSP_INVALID    = 6'd3,
    RSP_BUSY_READ  = 6'd9,
    RSP_BUSY_WRITE = 6'd10
  } respCodeE;

  // Feeds one byte into the CRC starting at its LSB
  function automatic logic [15:0] crc16Update(input logic [15:0] crcIn,
                                              input logic [7:0] dataByte);
    logic [15:0] crc;
    crc = crcIn ^ {8'h00, dataByte};
    for (int i = 0; i < 8; i++)
    begin
      if (crc[0])
        crc = (crc >> 1) ^ `CRC16_POLY;
      else
        crc = crc >> 1;
    end
    return crc;
  endfunction

endpackage

//--- hw/uartAxiBridge_macros.svh
// Byte-stream to AXI-Lite bridge constants for framing, CRC, signatures and queue sizing
`ifndef UART_AXI_BRIDGE_MACROS_SVH
`define UART_AXI_BRIDGE_MACROS_SVH

// Frame layout
`define MSG_BYTES 14
`define FRAME_BYTES 16

// Reflected CRC-16
`define CRC16_INIT 16'hFFFF
`define CRC16_POLY 16'hA001

// Fixed answer fields
`define NOP_ADDR_SIG 64'hDEAD_CAFE_1234_5678
`define NOP_DATA_SIG 32'h0000_0001
`define BAD_ADDR_SIG 64'h10BA_D0BA_D00D_AD00
`define BAD_DATA_SIG 32'hFFFF_FFFF

`define AXI_PROT_VALUE 3'b001
`define RESP_DEPTH 4

`endif

//--- tests/uartAxiBridgeTb.sv
// Bridge testbench with random command frames, a response model and an AXI slave model
`timescale 1ns/100ps
`include "uartAxiBridge_macros.svh"

module uartAxiBridgeTb
  import uartAxiBridgePkg::*;
();

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 8;
  localparam int RANDOM_FRAMES    = 24;
  localparam int TOTAL_FRAMES     = 12 + RANDOM_FRAMES;
  localparam int MAX_FRAME_CYCLES = 400;
  // Slave answers SLVERR above this address
  localparam logic [31:0] ERR_LIMIT = 32'hEFFF_FFFF;

  logic        clk, axi_resetn;
  logic [7:0]  rxByte, txByte;
  logic        rxByteValid, txReady, txByteStrobe;
  logic [31:0] axi_awaddr, axi_wdata, axi_araddr, axi_rdata;
  logic [2:0]  axi_awprot, axi_arprot;
  logic [3:0]  axi_wstrb;
  logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready;
  logic        axi_bvalid, axi_bready, axi_arvalid, axi_arready;
  logic        axi_rvalid, axi_rready;
  logic [1:0]  axi_bresp, axi_rresp;

  integer       seed = 32'h44f5_cf4e;
  int           mismatchCount = 0;
  int           otherCount = 0;
  int           txCount = 0;
  bit           randomReady = 1'b0;
  bit           arStall = 1'b0;
  bit           awStall = 1'b0;
  logic         prevStrobe = 1'b0;
  logic [7:0]   seqNum = 8'h10;
  logic [127:0] txFrame;
  logic [111:0] expQ [$];
  logic [31:0]  refMem [logic [31:0]];
  logic [31:0]  slaveMem [logic [31:0]];

  uartAxiBridge i_dut (.*);

  bind uartAxiBridge uartAxiBridgeProperties i_properties (
    .clk(clk), .axi_resetn(axi_resetn),
    .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
    .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
    .txReady(txReady), .txByteStrobe(txByteStrobe)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [127:0] got,
                            input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      mismatchCount++;
    end
  endtask

  // Unwritten words read back as a pattern of their address
  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return addr ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic [15:0] msgCrc(input logic [111:0] msg);
    logic [15:0] crc;
    crc = `CRC16_INIT;
    for (int i = 0; i < `MSG_BYTES; i++)
      crc = crc16Update(crc, msg[111-8*i -: 8]);
    return crc;
  endfunction

  function automatic logic [63:0] randAddr();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    // Narrow word range so reads often hit earlier writes
    return {hi, lo & 32'h0000_00FC};
  endfunction

  // Expected answer to one command with the reference memory following good writes
  function automatic logic [111:0] predict(input logic [7:0] cmd, input logic [7:0] seq,
                                           input logic [63:0] addr, input logic [31:0] data);
    logic [31:0] a;
    logic [1:0]  resp;
    logic [31:0] rd;
    a    = addr[31:0];
    resp = (a > ERR_LIMIT) ? 2'b10 : 2'b00;
    case (cmd[5:0])
      6'd0: return {2'b00, RSP_NOP, seq, `NOP_ADDR_SIG, `NOP_DATA_SIG};
      6'd1:
      begin
        rd = refMem.exists(a) ? refMem[a] : fillWord(a);
        return {resp, RSP_READ, seq, addr, (resp == 2'b00) ? rd : 32'h0};
      end
      6'd2:
      begin
        if (resp == 2'b00)
          refMem[a] = data;
        return {resp, RSP_WRITE, seq, addr, data};
      end
      default: return {2'b00, RSP_INVALID, seq, `BAD_ADDR_SIG, `BAD_DATA_SIG};
    endcase
  endfunction

  task automatic sendFrame(input logic [111:0] msg, input bit corrupt);
    logic [15:0]  crc;
    logic [127:0] frame;
    crc = msgCrc(msg);
    if (corrupt)
      crc[0] = ~crc[0];
    frame = {msg, crc[7:0], crc[15:8]};
    for (int i = 0; i < `FRAME_BYTES; i++)
    begin
      @(posedge clk);
      #2;
      rxByte      = frame[127-8*i -: 8];
      rxByteValid = 1'b1;
    end
    @(posedge clk);
    #2;
    rxByteValid = 1'b0;
  endtask

  task automatic waitQueue(input int remaining);
    int cycles;
    cycles = 0;
    while ((expQ.size() > remaining) && (cycles < 2 * MAX_FRAME_CYCLES))
    begin
      @(posedge clk);
      cycles++;
    end
    if (expQ.size() > remaining)
    begin
      $display("Timeout at %0t ns: %0d responses never arrived", $time, expQ.size());
      otherCount++;
      expQ.delete();
    end
  endtask

  task automatic runCommand(input logic [7:0] cmd, input logic [63:0] addr,
                            input logic [31:0] data);
    expQ.push_back(predict(cmd, seqNum, addr, data));
    sendFrame({cmd, seqNum, addr, data}, 1'b0);
    seqNum++;
    waitQueue(0);
  endtask

  // First command stalls on its address channel while the second one is turned away
  task automatic stalledPair(input bit isWrite);
    logic [7:0]  cmd;
    logic [63:0] a1, a2;
    logic [31:0] d1, d2;
    cmd = isWrite ? 8'h02 : 8'h01;
    a1  = randAddr();
    a2  = randAddr();
    d1  = $random(seed);
    d2  = $random(seed);
    if (isWrite)
    begin
      awStall = 1'b1;
      expQ.push_back({2'b00, RSP_BUSY_WRITE, seqNum + 8'd1, a2, d2});
    end
    else
    begin
      arStall = 1'b1;
      expQ.push_back({2'b00, RSP_BUSY_READ, seqNum + 8'd1, a2, 32'h0});
    end
    expQ.push_back(predict(cmd, seqNum, a1, d1));
    sendFrame({cmd, seqNum, a1, d1}, 1'b0);
    sendFrame({cmd, seqNum + 8'd1, a2, d2}, 1'b0);
    seqNum += 8'd2;
    waitQueue(1);
    repeat (10) @(posedge clk);
    arStall = 1'b0;
    awStall = 1'b0;
    waitQueue(0);
  endtask

  task automatic checkFrame(input logic [127:0] frame);
    logic [111:0] expMsg;
    checkValue("response CRC", {frame[7:0], frame[15:8]}, msgCrc(frame[127:16]));
    if (expQ.size() == 0)
    begin
      $display("Unexpected response frame at %0t ns: %h", $time, frame);
      otherCount++;
    end
    else
    begin
      expMsg = expQ.pop_front();
      checkValue("response message", frame[127:16], expMsg);
    end
  endtask

  // Collect transmitted bytes mid-cycle where the strobe is stable
  always @(negedge clk)
  begin
    if (axi_resetn)
    begin
      checkValue("tx strobe outside a ready cycle", txByteStrobe && !txReady, 1'b0);
      checkValue("tx strobes on adjacent cycles", txByteStrobe && prevStrobe, 1'b0);
      prevStrobe = txByteStrobe;
      if (txByteStrobe)
      begin
        txFrame = {txFrame[119:0], txByte};
        txCount++;
        if (txCount == `FRAME_BYTES)
        begin
          checkFrame(txFrame);
          txCount = 0;
        end
      end
    end
  end

  initial
  begin
    txReady = 1'b1;
    forever
    begin
      @(posedge clk);
      #2;
      txReady = randomReady ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  // AXI-Lite slave model that samples handshakes mid-cycle and answers after the edge
  initial
  begin : slaveModel
    logic        arHs, rHs, awHs, wHs, bHs, arPend, awPend, haveAw, haveW;
    logic [31:0] rdAddr, wrAddr, wrData;
    axi_arready = 1'b0;
    axi_awready = 1'b0;
    axi_wready  = 1'b1;
    axi_rvalid  = 1'b0;
    axi_rdata   = '0;
    axi_rresp   = 2'b00;
    axi_bvalid  = 1'b0;
    axi_bresp   = 2'b00;
    arPend      = 1'b0;
    awPend      = 1'b0;
    haveAw      = 1'b0;
    haveW       = 1'b0;
    forever
    begin
      @(negedge clk);
      if (arPend)
        checkValue("arvalid held until arready", axi_arvalid, 1'b1);
      if (awPend)
        checkValue("awvalid held until awready", axi_awvalid, 1'b1);
      arPend = axi_arvalid && !axi_arready;
      awPend = axi_awvalid && !axi_awready;
      arHs   = axi_arvalid && axi_arready;
      rHs    = axi_rvalid && axi_rready;
      awHs   = axi_awvalid && axi_awready;
      wHs    = axi_wvalid && axi_wready;
      bHs    = axi_bvalid && axi_bready;
      if (arHs)
      begin
        rdAddr = axi_araddr;
        checkValue("arprot", axi_arprot, `AXI_PROT_VALUE);
      end
      if (awHs)
      begin
        wrAddr = axi_awaddr;
        checkValue("awprot", axi_awprot, `AXI_PROT_VALUE);
      end
      if (wHs)
      begin
        wrData = axi_wdata;
        checkValue("wstrb", axi_wstrb, 4'hF);
      end
      @(posedge clk);
      #2;
      axi_arready = !arStall;
      axi_awready = !awStall;
      if (rHs)
        axi_rvalid = 1'b0;
      if (bHs)
        axi_bvalid = 1'b0;
      if (arHs)
      begin
        axi_rvalid = 1'b1;
        axi_rresp  = (rdAddr > ERR_LIMIT) ? 2'b10 : 2'b00;
        if (rdAddr > ERR_LIMIT)
          axi_rdata = 32'h0;
        else
          axi_rdata = slaveMem.exists(rdAddr) ? slaveMem[rdAddr] : fillWord(rdAddr);
      end
      haveAw = haveAw || awHs;
      haveW  = haveW || wHs;
      if (haveAw && haveW)
      begin
        if (wrAddr <= ERR_LIMIT)
          slaveMem[wrAddr] = wrData;
        axi_bresp  = (wrAddr > ERR_LIMIT) ? 2'b10 : 2'b00;
        axi_bvalid = 1'b1;
        haveAw     = 1'b0;
        haveW      = 1'b0;
      end
    end
  end

  initial
  begin
    #((TOTAL_FRAMES + 2) * MAX_FRAME_CYCLES * CLK_PERIOD);
    $display("Watchdog expired at %0t ns, the test did not finish", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin : mainSequence
    logic [63:0] addr;
    logic [31:0] data;
    logic [31:0] r;
    logic [7:0]  cmd;
    rxByte      = 8'h00;
    rxByteValid = 1'b0;
    axi_resetn  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    axi_resetn = 1'b1;
    @(negedge clk);
    checkValue("outputs after reset",
               {axi_arvalid, axi_awvalid, axi_wvalid, axi_rready, axi_bready, txByteStrobe},
               6'b000110);

    // NOP signature
    runCommand(8'h00, randAddr(), $random(seed));

    // Write and read back, then the same in the SLVERR range with upper bits set
    addr = randAddr();
    data = $random(seed);
    runCommand(8'h02, addr, data);
    runCommand(8'h01, addr, 32'h0);
    addr[31:28] = 4'hF;
    runCommand(8'hC2, addr, data);
    runCommand(8'h41, addr, 32'h0);

    // Bad CRC gets no answer but the good frame after it does
    sendFrame({8'h02, seqNum, randAddr(), 32'h1234_5678}, 1'b1);
    seqNum++;
    runCommand(8'h00, randAddr(), 32'h0);

    stalledPair(1'b0);
    stalledPair(1'b1);

    // Undefined opcode
    runCommand(8'h15, randAddr(), $random(seed));

    randomReady = 1'b1;
    for (int n = 0; n < RANDOM_FRAMES; n++)
    begin
      r    = $random(seed);
      cmd  = {r[9:8], (r[1:0] == 2'd3) ? {1'b1, r[6:2]} : {4'd0, r[1:0]}};
      addr = randAddr();
      if (r[14:12] == 3'd0)
        addr[31:28] = 4'hF;
      runCommand(cmd, addr, $random(seed));
    end
    randomReady = 1'b0;

    // Let any stray frame show up before closing
    repeat (MAX_FRAME_CYCLES) @(posedge clk);
    if (txCount != 0)
    begin
      $display("Response frame cut short after %0d bytes", txCount);
      otherCount++;
    end
    $display("Run complete: %0d value mismatches, %0d other errors",
             mismatchCount, otherCount);
    if ((mismatchCount == 0) && (otherCount == 0))
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- tests/uartAxiBridge_properties.sv
// Bridge handshake properties for AXI address channels and the transmit byte strobe
`timescale 1ns/100ps

module uartAxiBridgeProperties (
  input logic clk,
  input logic axi_resetn,
  input logic axi_arvalid,
  input logic axi_arready,
  input logic axi_awvalid,
  input logic axi_awready,
  input logic txReady,
  input logic txByteStrobe
);

  // Address valids only drop after their handshake
  arHeld: assert property (@(posedge clk) disable iff (!axi_resetn)
                           (axi_arvalid && !axi_arready) |=> axi_arvalid)
    else $error("arvalid dropped before arready");

  awHeld: assert property (@(posedge clk) disable iff (!axi_resetn)
                           (axi_awvalid && !axi_awready) |=> axi_awvalid)
    else $error("awvalid dropped before awready");

  // Bytes leave only in a ready cycle, never two in a row
  txOnReady: assert property (@(posedge clk) disable iff (!axi_resetn)
                              txByteStrobe |-> txReady)
    else $error("txByteStrobe while txReady low");

  txSpaced: assert property (@(posedge clk) disable iff (!axi_resetn)
                             txByteStrobe |=> !txByteStrobe)
    else $error("txByteStrobe on two consecutive cycles");

endmodule

//--- uartAxiBridge.f
+incdir+hw
hw/uartAxiBridgePkg.sv
hw/frameReceiver.sv
hw/commandEngine.sv
hw/responseQueue.sv
hw/frameTransmitter.sv
hw/uartAxiBridge.sv
tests/uartAxiBridge_properties.sv
tests/uartAxiBridgeTb.sv
